/* microCpu.f */
+incdir+sim
common/cpuPkg.sv
source/sequencer.sv
source/progMem.sv
source/aluUnit.sv
memIo/dataRam.sv
memIo/memIoUnit.sv
source/regFile.sv
source/microCpu.sv
sim/cpuTb.sv

/* Makefile */
# Verilator build and run for the microCpu testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f microCpu.f --top-module cpuTb -o cpuTb
	./obj_dir/cpuTb

lint:
	verilator --lint-only -Wall --timing -f microCpu.f --top-module cpuTb

clean:
	rm -rf obj_dir

/* sim/cpuTbTasks.svh */
`ifndef CPU_TB_TASKS_SVH
`define CPU_TB_TASKS_SVH

// ****************************************
// Reporting
// ****************************************
task automatic stopOnFailure();
    $display("TEST FAIL");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic checkEq(input cpuPkg::dataT got, input cpuPkg::dataT expected,
                       input string what);
    if (got !== expected) begin
        $display("MISMATCH at %0t ns: %s, got %02h expected %02h",
                 $time, what, got, expected);
        stopOnFailure();
    end
endtask

function automatic cpuPkg::dataT randByte();
    int r;
    r = $random(seed);
    return r[7:0];
endfunction

// ****************************************
// Program building and running
// ****************************************
task automatic emit(input cpuPkg::regIdxT dst, input cpuPkg::dataT imm,
                    input cpuPkg::opT op);
    prog.push_back({dst, imm, op});                 // dst | imm | opcode
endtask

task automatic emitRegOp(input cpuPkg::regIdxT dst, input cpuPkg::regIdxT src,
                         input cpuPkg::opT op);
    emit(dst, {src, 4'h0}, op);                     // Source sits in imm[7:4]
endtask

task automatic loadProgram();
    for (int i = 0; i < prog.size(); i++) begin
        @(negedge clk);
        run      = 1'b0;
        progWe   = 1'b1;
        progAddr = i[7:0];
        progData = prog[i];
    end
    @(negedge clk);
    progWe = 1'b0;
endtask

task automatic runToHalt();
    @(negedge clk);
    run = 1'b1;
    @(negedge clk);
    while (!halted)
        @(negedge clk);                             // Watchdog bounds this
endtask

task automatic stopCore();
    @(negedge clk);
    run = 1'b0;
    prog.delete();
endtask

task automatic runAndCheckPort(input cpuPkg::dataT expected, input string what);
    loadProgram();
    runToHalt();
    checkEq(gpioOut, expected, what);
    stopCore();
endtask

// ****************************************
// Tests
// ****************************************
task automatic checkResetState();
    checkEq({7'b0, halted}, 8'h00, "halted after reset");
    checkEq(gpioOe, 8'h00, "gpioOe after reset");
    checkEq(gpioOut, 8'h00, "gpioOut after reset");
endtask

// Two register operands with the result stored to the port
task automatic checkBinOp(input cpuPkg::opT op, input cpuPkg::dataT a, input cpuPkg::dataT b,
                          input cpuPkg::dataT expected, input string what);
    emit(4'd15, cpuPkg::IO_PAGE, cpuPkg::OP_LDI);
    emit(4'd1, 8'hFF, cpuPkg::OP_LDI);
    emit(4'd1, cpuPkg::IO_DIR, cpuPkg::OP_ST);
    emit(4'd2, a, cpuPkg::OP_LDI);
    emit(4'd3, b, cpuPkg::OP_LDI);
    emitRegOp(4'd2, 4'd3, op);
    emit(4'd2, cpuPkg::IO_PORT, cpuPkg::OP_ST);
    emit(4'd0, 8'h00, cpuPkg::OP_HALT);
    loadProgram();
    runToHalt();
    checkEq(gpioOe, 8'hFF, "direction register");
    checkEq(gpioOut, expected, what);
    stopCore();
endtask

// Marker survives only if the jump skips the clearing LDI
task automatic checkBranch(input cpuPkg::opT jumpOp, input cpuPkg::opT aluOp,
                           input cpuPkg::dataT a, input cpuPkg::dataT b,
                           input logic taken, input string what);
    int n;
    emit(4'd15, cpuPkg::IO_PAGE, cpuPkg::OP_LDI);
    emit(4'd2, a, cpuPkg::OP_LDI);
    emit(4'd3, b, cpuPkg::OP_LDI);
    emit(4'd4, MARK, cpuPkg::OP_LDI);
    emitRegOp(4'd2, 4'd3, aluOp);
    n = prog.size() + 2;
    emit(4'd0, n[7:0], jumpOp);
    emit(4'd4, 8'h00, cpuPkg::OP_LDI);
    emit(4'd4, cpuPkg::IO_PORT, cpuPkg::OP_ST);
    emit(4'd0, 8'h00, cpuPkg::OP_HALT);
    runAndCheckPort(taken ? MARK : 8'h00, what);
endtask

task automatic testArith();
    cpuPkg::dataT a;
    cpuPkg::dataT b;
    cpuPkg::dataT sum;
    cpuPkg::dataT diff;
    a    = randByte();
    b    = randByte();
    sum  = a + b;                                   // Modulo 256
    diff = a - b;
    checkBinOp(cpuPkg::OP_ADD, a, b, sum, "ADD result");
    checkBinOp(cpuPkg::OP_SUB, a, b, diff, "SUB result");
endtask

task automatic testLogic();
    cpuPkg::dataT a;
    cpuPkg::dataT b;
    a = randByte();
    b = randByte();
    checkBinOp(cpuPkg::OP_AND, a, b, a & b, "AND result");
    checkBinOp(cpuPkg::OP_OR, a, b, a | b, "OR result");
    checkBinOp(cpuPkg::OP_XOR, a, b, a ^ b, "XOR result");
    // F0 plus 20 is 110, so carry is set
    checkBranch(cpuPkg::OP_JC, cpuPkg::OP_ADD, 8'hF0, 8'h20, 1'b1, "JC after ADD");
    checkBranch(cpuPkg::OP_JZ, cpuPkg::OP_SUB, a, a, 1'b1, "JZ after SUB to zero");
endtask

task automatic testRam();
    cpuPkg::dataT v;
    cpuPkg::dataT lo;
    v  = randByte();
    lo = randByte();
    emit(4'd15, 8'h03, cpuPkg::OP_LDI);             // RAM page 3
    emit(4'd1, v, cpuPkg::OP_LDI);
    emit(4'd1, lo, cpuPkg::OP_ST);
    emit(4'd2, ~v, cpuPkg::OP_LDI);
    emit(4'd2, lo, cpuPkg::OP_LD);
    emit(4'd15, cpuPkg::IO_PAGE, cpuPkg::OP_LDI);
    emit(4'd2, cpuPkg::IO_PORT, cpuPkg::OP_ST);
    emit(4'd0, 8'h00, cpuPkg::OP_HALT);
    runAndCheckPort(v, "RAM round trip");
endtask

task automatic testPins();
    cpuPkg::dataT p;
    p = randByte();
    @(negedge clk);
    gpioIn = p;
    emit(4'd15, cpuPkg::IO_PAGE, cpuPkg::OP_LDI);
    emit(4'd1, ~p, cpuPkg::OP_LDI);
    emit(4'd1, cpuPkg::IO_PINS, cpuPkg::OP_LD);
    emit(4'd1, cpuPkg::IO_PORT, cpuPkg::OP_ST);
    emit(4'd0, 8'h00, cpuPkg::OP_HALT);
    runAndCheckPort(p, "input pins to port");
endtask

task automatic testHaltHold();
    cpuPkg::dataT v;
    v = randByte();
    emit(4'd15, cpuPkg::IO_PAGE, cpuPkg::OP_LDI);
    emit(4'd5, v, cpuPkg::OP_LDI);
    emit(4'd7, ~v, cpuPkg::OP_LDI);
    emit(4'd5, cpuPkg::IO_PORT, cpuPkg::OP_ST);
    emit(4'd0, 8'h00, cpuPkg::OP_HALT);
    emit(4'd7, cpuPkg::IO_PORT, cpuPkg::OP_ST);     // Would overwrite the port
    loadProgram();
    runToHalt();
    repeat (20) begin
        @(negedge clk);
        checkEq(gpioOut, v, "port held after HALT");
        checkEq({7'b0, halted}, 8'h01, "halted stays set");
    end
    stopCore();
    // Reload and restart with a different value
    emit(4'd15, cpuPkg::IO_PAGE, cpuPkg::OP_LDI);
    emit(4'd6, ~v, cpuPkg::OP_LDI);
    emit(4'd6, cpuPkg::IO_PORT, cpuPkg::OP_ST);
    emit(4'd0, 8'h00, cpuPkg::OP_HALT);
    runAndCheckPort(~v, "second program after restart");
endtask

`endif

/* sim/cpuTb.sv */
`timescale 1ns/100ps

module cpuTb;

    // Eleven program runs of under 40 cycles each plus a 20 cycle hold
    // 3000 sits far above twice their sum
    localparam int           MAX_CYCLES = 3000;
    localparam cpuPkg::dataT MARK       = 8'hA5;    // Stored when a branch is taken

    logic             clk = 1'b0;
    logic             rstN;
    logic             run;
    logic             progWe;
    cpuPkg::progAddrT progAddr;
    cpuPkg::instrT    progData;
    cpuPkg::dataT     gpioIn;
    cpuPkg::dataT     gpioOut;
    cpuPkg::dataT     gpioOe;
    logic             halted;

    cpuPkg::instrT    prog [$];                     // Program being built
    int               seed   = 32'h6c9f_2d98;
    int               cycles = 0;

    microCpu DUT (
        .clk     (clk),
        .rstN    (rstN),
        .run     (run),
        .progWe  (progWe),
        .progAddr(progAddr),
        .progData(progData),
        .gpioIn  (gpioIn),
        .gpioOut (gpioOut),
        .gpioOe  (gpioOe),
        .halted  (halted)
    );

    always #5 clk = ~clk;                           // 10 ns period

    `include "cpuTbTasks.svh"

    // ****************************************
    // Watchdog
    // ****************************************
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            stopOnFailure();
        end
    end

    // ****************************************
    // Test sequence
    // ****************************************
    initial begin
        rstN     = 1'b0;
        run      = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        gpioIn   = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        checkResetState();
        testArith();
        testLogic();
        testRam();
        testPins();
        testHaltHold();

        $display("TEST PASS");
        $finish;
    end

endmodule

/* source/microCpu.sv */
`timescale 1ns/100ps

module microCpu (
    input  logic             clk,
    input  logic             rstN,
    input  logic             run,
    input  logic             progWe,
    input  cpuPkg::progAddrT progAddr,
    input  cpuPkg::instrT    progData,
    input  cpuPkg::dataT     gpioIn,
    output cpuPkg::dataT     gpioOut,
    output cpuPkg::dataT     gpioOe,
    output logic             halted
);
    cpuPkg::progAddrT fetchAddr;
    logic             fetchEn;
    cpuPkg::instrT    instr;
    cpuPkg::aluCtrlT  aluCtrl;
    cpuPkg::busReqT   busReq;
    cpuPkg::wbCtrlT   wbCtrl;
    cpuPkg::flagsT    flags;
    cpuPkg::regIdxT   srcIdx;
    cpuPkg::regIdxT   dstIdx;
    cpuPkg::dataT     imm;
    cpuPkg::dataT     dstVal;
    cpuPkg::dataT     srcVal;
    cpuPkg::dataT     pageReg;
    cpuPkg::dataT     aluResult;
    cpuPkg::dataT     memData;

    sequencer seq (
        .clk      (clk),
        .rstN     (rstN),
        .run      (run),
        .instr    (instr),
        .flags    (flags),
        .pageReg  (pageReg),
        .dstVal   (dstVal),
        .fetchAddr(fetchAddr),
        .fetchEn  (fetchEn),
        .aluCtrl  (aluCtrl),
        .busReq   (busReq),
        .wbCtrl   (wbCtrl),
        .srcIdx   (srcIdx),
        .dstIdx   (dstIdx),
        .imm      (imm),
        .halted   (halted)
    );

    progMem prog (
        .clk      (clk),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .fetchAddr(fetchAddr),
        .fetchEn  (fetchEn),
        .instr    (instr)
    );

    // ALU and bus unit share the same decoded instruction
    aluUnit alu (
        .clk    (clk),
        .rstN   (rstN),
        .aluCtrl(aluCtrl),
        .dstVal (dstVal),
        .srcVal (srcVal),
        .imm    (imm),
        .result (aluResult),
        .flags  (flags)
    );

    memIoUnit memIo (
        .clk    (clk),
        .rstN   (rstN),
        .busReq (busReq),
        .gpioIn (gpioIn),
        .rData  (memData),
        .gpioOut(gpioOut),
        .gpioOe (gpioOe)
    );

    regFile regs (
        .clk      (clk),
        .rstN     (rstN),
        .wbCtrl   (wbCtrl),
        .aluResult(aluResult),
        .memData  (memData),
        .imm      (imm),
        .dstIdx   (dstIdx),
        .srcIdx   (srcIdx),
        .dstVal   (dstVal),
        .srcVal   (srcVal),
        .pageReg  (pageReg)
    );

endmodule

/* source/regFile.sv */
`timescale 1ns/100ps

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  cpuPkg::wbCtrlT wbCtrl,
    input  cpuPkg::dataT   aluResult,
    input  cpuPkg::dataT   memData,
    input  cpuPkg::dataT   imm,
    input  cpuPkg::regIdxT dstIdx,
    input  cpuPkg::regIdxT srcIdx,
    output cpuPkg::dataT   dstVal,
    output cpuPkg::dataT   srcVal,
    output cpuPkg::dataT   pageReg
);
    cpuPkg::dataT regs [16];
    cpuPkg::dataT wbVal;

    // ****************************************
    // Write-back select
    // ****************************************
    always_comb begin
        case (wbCtrl.src)
            cpuPkg::WB_IMM: wbVal = imm;
            cpuPkg::WB_MEM: wbVal = memData;
            default:        wbVal = aluResult;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 16; i++)
                regs[i] <= '0;
        end else if (wbCtrl.we) begin
            regs[wbCtrl.dst] <= wbVal;
        end
    end

    // Asynchronous read ports
    assign dstVal  = regs[dstIdx];
    assign srcVal  = regs[srcIdx];
    assign pageReg = regs[15];            // High byte of every bus address

endmodule

/* memIo/memIoUnit.sv */
`timescale 1ns/100ps

module memIoUnit (
    input  logic           clk,
    input  logic           rstN,
    input  cpuPkg::busReqT busReq,
    input  cpuPkg::dataT   gpioIn,
    output cpuPkg::dataT   rData,
    output cpuPkg::dataT   gpioOut,
    output cpuPkg::dataT   gpioOe
);
    cpuPkg::dataT page;
    cpuPkg::dataT low;
    cpuPkg::dataT ramData;
    cpuPkg::dataT ioData;
    cpuPkg::dataT dirReg;
    cpuPkg::dataT portReg;
    logic         ramSel;
    logic         ioSel;
    logic         ramRd;                 // Source of the pending read data
    logic         ioRd;

    // ****************************************
    // Address decode
    // ****************************************
    assign page   = busReq.addr[15:8];
    assign low    = busReq.addr[7:0];
    assign ramSel = (page[7:4] == 4'h0);          // Pages 0x00 to 0x0F
    assign ioSel  = (page == cpuPkg::IO_PAGE);

    dataRam ram (
        .clk  (clk),
        .addr (busReq.addr[cpuPkg::DATA_RAM_AW-1:0]),
        .wData(busReq.wData),
        .we   (busReq.we && ramSel),
        .re   (busReq.re && ramSel),
        .rData(ramData)
    );

    // GPIO registers
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dirReg  <= '0;
            portReg <= '0;
        end else if (busReq.we && ioSel) begin
            if (low == cpuPkg::IO_DIR)
                dirReg <= busReq.wData;
            if (low == cpuPkg::IO_PORT)
                portReg <= busReq.wData;
        end
    end

    always_ff @(posedge clk) begin
        if (busReq.re && ioSel) begin
            case (low)
                cpuPkg::IO_DIR:  ioData <= dirReg;
                cpuPkg::IO_PORT: ioData <= portReg;
                cpuPkg::IO_PINS: ioData <= gpioIn;    // Pins sampled here
                default:         ioData <= '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ramRd <= 1'b0;
            ioRd  <= 1'b0;
        end else if (busReq.re) begin
            ramRd <= ramSel;
            ioRd  <= ioSel;
        end
    end

    // Unmapped pages return zero
    assign rData   = ramRd ? ramData : (ioRd ? ioData : '0);
    assign gpioOut = portReg;
    assign gpioOe  = dirReg;

    assert property (@(posedge clk) disable iff (!rstN) busReq.we |-> (ramSel || ioSel));

endmodule

/* memIo/dataRam.sv */
`timescale 1ns/100ps

module dataRam (
    input  logic                            clk,
    input  logic [cpuPkg::DATA_RAM_AW-1:0] addr,
    input  cpuPkg::dataT                    wData,
    input  logic                            we,
    input  logic                            re,
    output cpuPkg::dataT                    rData
);
    cpuPkg::dataT mem [cpuPkg::DATA_RAM_WORDS];

    // Single port, read data one cycle after re
    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= wData;
        if (re)
            rData <= mem[addr];
    end

endmodule

/* source/aluUnit.sv */
`timescale 1ns/100ps

module aluUnit (
    input  logic            clk,
    input  logic            rstN,
    input  cpuPkg::aluCtrlT aluCtrl,
    input  cpuPkg::dataT    dstVal,
    input  cpuPkg::dataT    srcVal,
    input  cpuPkg::dataT    imm,
    output cpuPkg::dataT    result,
    output cpuPkg::flagsT   flags
);
    cpuPkg::dataT opB;
    logic [8:0]   wide;                   // Bit 8 is carry or borrow

    assign opB = aluCtrl.immSel ? imm : srcVal;

    // ****************************************
    // Operations
    // ****************************************
    always_comb begin
        case (aluCtrl.op)
            cpuPkg::OP_ADD,
            cpuPkg::OP_ADDI: wide = {1'b0, dstVal} + {1'b0, opB};
            cpuPkg::OP_SUB:  wide = {1'b0, dstVal} - {1'b0, opB};
            cpuPkg::OP_AND:  wide = {1'b0, dstVal & opB};
            cpuPkg::OP_OR:   wide = {1'b0, dstVal | opB};
            cpuPkg::OP_XOR:  wide = {1'b0, dstVal ^ opB};
            default:         wide = {1'b0, dstVal};
        endcase
    end

    assign result = wide[7:0];

    // Flags register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            flags <= '0;
        end else if (aluCtrl.flagWe) begin
            flags.zero  <= (wide[7:0] == 8'h00);
            flags.carry <= wide[8];       // Logic ops leave bit 8 clear
        end
    end

endmodule

/* source/progMem.sv */
`timescale 1ns/100ps

module progMem (
    input  logic             clk,
    input  logic             progWe,
    input  cpuPkg::progAddrT progAddr,
    input  cpuPkg::instrT    progData,
    input  cpuPkg::progAddrT fetchAddr,
    input  logic             fetchEn,
    output cpuPkg::instrT    instr
);
    cpuPkg::instrT mem [cpuPkg::PROG_WORDS];

    // Host load port
    always_ff @(posedge clk) begin
        if (progWe)
            mem[progAddr] <= progData;
    end

    // Fetch port, word valid in the cycle after fetchEn
    always_ff @(posedge clk) begin
        if (fetchEn)
            instr <= mem[fetchAddr];
    end

endmodule

/* source/sequencer.sv */
`timescale 1ns/100ps

module sequencer (
    input  logic             clk,
    input  logic             rstN,
    input  logic             run,
    input  cpuPkg::instrT    instr,
    input  cpuPkg::flagsT    flags,
    input  cpuPkg::dataT     pageReg,
    input  cpuPkg::dataT     dstVal,
    output cpuPkg::progAddrT fetchAddr,
    output logic             fetchEn,
    output cpuPkg::aluCtrlT  aluCtrl,
    output cpuPkg::busReqT   busReq,
    output cpuPkg::wbCtrlT   wbCtrl,
    output cpuPkg::regIdxT   srcIdx,
    output cpuPkg::regIdxT   dstIdx,
    output cpuPkg::dataT     imm,
    output logic             halted
);
    cpuPkg::seqStateT state;
    cpuPkg::progAddrT pc;
    cpuPkg::instrT    ir;
    cpuPkg::instrT    curInstr;
    cpuPkg::opT       op;
    logic             exec;
    logic             aluOp;
    logic             jumpTaken;

    // Fresh word from progMem in S_EXEC and the held copy in S_LOAD
    assign exec     = (state == cpuPkg::S_EXEC);
    assign curInstr = exec ? instr : ir;
    assign op       = curInstr[3:0];
    assign dstIdx   = curInstr[15:12];
    assign srcIdx   = curInstr[11:8];
    assign imm      = curInstr[11:4];
    assign aluOp    = (op >= cpuPkg::OP_ADD) && (op <= cpuPkg::OP_ADDI);

    always_comb begin
        case (op)
            cpuPkg::OP_JMP: jumpTaken = 1'b1;
            cpuPkg::OP_JZ:  jumpTaken = flags.zero;
            cpuPkg::OP_JC:  jumpTaken = flags.carry;
            default:        jumpTaken = 1'b0;
        endcase
    end

    // ****************************************
    // State machine and program counter
    // ****************************************
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= cpuPkg::S_FETCH;
            pc    <= '0;
        end else if (!run) begin             // Restart from zero while stopped
            state <= cpuPkg::S_FETCH;
            pc    <= '0;
        end else begin
            case (state)
                cpuPkg::S_FETCH: state <= cpuPkg::S_EXEC;
                cpuPkg::S_EXEC: begin
                    pc <= jumpTaken ? imm : pc + 8'd1;
                    if (op == cpuPkg::OP_LD)
                        state <= cpuPkg::S_LOAD;
                    else if (op == cpuPkg::OP_HALT)
                        state <= cpuPkg::S_HALT;
                    else
                        state <= cpuPkg::S_FETCH;
                end
                cpuPkg::S_LOAD: state <= cpuPkg::S_FETCH;
                default:        state <= cpuPkg::S_HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (exec)
            ir <= instr;                      // Kept for the load write-back
    end

    assign fetchAddr = pc;
    assign fetchEn   = run && (state == cpuPkg::S_FETCH);
    assign halted    = (state == cpuPkg::S_HALT);

    // ****************************************
    // Decode into the three control bundles
    // ****************************************
    always_comb begin
        aluCtrl.op     = op;
        aluCtrl.immSel = (op == cpuPkg::OP_ADDI);
        aluCtrl.flagWe = exec && aluOp;

        busReq.addr  = {pageReg, imm};        // R15 is the page
        busReq.wData = dstVal;
        busReq.we    = exec && (op == cpuPkg::OP_ST);
        busReq.re    = exec && (op == cpuPkg::OP_LD);

        wbCtrl.dst = dstIdx;
        wbCtrl.we  = 1'b0;
        wbCtrl.src = cpuPkg::WB_ALU;
        if (exec && (op == cpuPkg::OP_LDI)) begin
            wbCtrl.we  = 1'b1;
            wbCtrl.src = cpuPkg::WB_IMM;
        end else if (exec && aluOp) begin
            wbCtrl.we = 1'b1;
        end else if (state == cpuPkg::S_LOAD) begin
            wbCtrl.we  = 1'b1;
            wbCtrl.src = cpuPkg::WB_MEM;
        end
    end

    // One bus transfer per execute cycle
    assert property (@(posedge clk) disable iff (!rstN) !(busReq.we && busReq.re));

endmodule

/* common/cpuPkg.sv */
package cpuPkg;

    // ****************************************
    // Widths
    // ****************************************
    typedef logic [7:0]  dataT;
    typedef logic [15:0] instrT;      // dst[15:12] imm[11:4] op[3:0]
    typedef logic [7:0]  progAddrT;
    typedef logic [15:0] busAddrT;
    typedef logic [3:0]  regIdxT;
    typedef logic [3:0]  opT;
    typedef logic [1:0]  wbSrcT;

    // ****************************************
    // Opcodes
    // ****************************************
    localparam opT OP_NOP  = 4'h0;
    localparam opT OP_LDI  = 4'h1;
    localparam opT OP_ADD  = 4'h2;
    localparam opT OP_SUB  = 4'h3;
    localparam opT OP_AND  = 4'h4;
    localparam opT OP_OR   = 4'h5;
    localparam opT OP_XOR  = 4'h6;
    localparam opT OP_ADDI = 4'h7;
    localparam opT OP_LD   = 4'h8;
    localparam opT OP_ST   = 4'h9;
    localparam opT OP_JMP  = 4'hA;
    localparam opT OP_JZ   = 4'hB;
    localparam opT OP_JC   = 4'hC;
    localparam opT OP_HALT = 4'hF;    // D and E decode as NOP

    // Memory map
    localparam dataT IO_PAGE = 8'h10;
    localparam dataT IO_DIR  = 8'h00;
    localparam dataT IO_PORT = 8'h01;
    localparam dataT IO_PINS = 8'h02;

    localparam int DATA_RAM_WORDS = 4096;
    localparam int DATA_RAM_AW    = $clog2(DATA_RAM_WORDS);
    localparam int PROG_WORDS     = 256;

    // Write-back sources
    localparam wbSrcT WB_ALU = 2'd0;
    localparam wbSrcT WB_IMM = 2'd1;
    localparam wbSrcT WB_MEM = 2'd2;

    // ****************************************
    // Control bundles
    // ****************************************
    typedef struct packed {
        opT   op;
        logic immSel;                 // Second operand from the immediate
        logic flagWe;
    } aluCtrlT;

    typedef struct packed {
        busAddrT addr;
        dataT    wData;
        logic    we;
        logic    re;
    } busReqT;

    typedef struct packed {
        logic   we;
        regIdxT dst;
        wbSrcT  src;
    } wbCtrlT;

    typedef struct packed {
        logic zero;
        logic carry;
    } flagsT;

    typedef enum logic [1:0] {
        S_FETCH,
        S_EXEC,
        S_LOAD,
        S_HALT
    } seqStateT;

endpackage
